// ==== verilog/store_pkg.sv ====
/*
 * shared definitions for the store path of the load/store unit
 * widths, queue depths, the store operation and FSM state encodings
 * and the layout of one queue entry; modules import it wildcard style
 */
package store_pkg;

    // --------------------
    // widths
    // --------------------
    // data path width, one doubleword
    localparam int XLEN = 64;
    // virtual and physical addresses share one width here
    localparam int ADDR_W = 32;
    localparam int TRANS_ID_W = 3;

    // --------------------
    // queue sizing
    // --------------------
    localparam int SPEC_DEPTH = 4;
    localparam int COMMIT_DEPTH = 4;
    // wide enough to hold a count of 0 up to the depth
    localparam int LEVEL_W = 3;

    // store width as decoded by issue
    typedef enum logic [1:0] {
        ST_SB,
        ST_SH,
        ST_SW,
        ST_SD
    } store_op_e;

    // store control FSM
    typedef enum logic [1:0] {
        IDLE,
        VALID_STORE,
        WAIT_TRANSLATION,
        WAIT_STORE_READY
    } store_state_e;

    // one translated and realigned store, as held in either queue
    typedef struct packed {
        logic [ADDR_W-1:0]   paddr;
        logic [XLEN-1:0]     data;
        logic [XLEN/8-1:0]   be;
        // 0 byte, 1 half, 2 word, 3 double
        logic [1:0]          size;
    } store_entry_t;

endpackage

// ==== verilog/store_req_if.sv ====
/*
 * one store on its way from the control path into the store queue
 * the FSM and the realign stage both drive it through the ctrl modport,
 * each its own fields; the queue samples it through the queue modport
 */
interface store_req_if;
    import store_pkg::*;

    // post pulse, already gated by flush
    logic              valid;
    // same pulse without the flush gate, only for offset matching
    logic              valid_nf;
    logic [ADDR_W-1:0] paddr;
    logic [XLEN-1:0]   data;
    logic [XLEN/8-1:0] be;
    logic [1:0]        size;

    modport ctrl (
        output valid, valid_nf, paddr, data, be, size
    );

    modport queue (
        input valid, valid_nf, paddr, data, be, size
    );

endinterface

// ==== verilog/store_ctrl.sv ====
/*
 * store control FSM
 * sequences the TLB request, the pop towards issue, the writeback pulse
 * and the post into the speculative queue; exceptions end a store
 * without posting it, a flush sends the FSM home
 */
module store_ctrl (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        flush_i,
    input  logic                        valid_i,
    output logic                        pop_st_o,
    output logic                        valid_o,
    input  logic                        ex_valid_i,
    output logic                        ex_valid_o,
    output logic                        translation_req_o,
    input  logic                        dtlb_hit_i,
    input  logic [store_pkg::ADDR_W-1:0] paddr_i,
    input  logic                        st_ready_i,
    store_req_if.ctrl                   st
);
    import store_pkg::*;

    store_state_e      state_d, state_q;
    logic              st_valid;
    logic              st_valid_nf;
    logic [ADDR_W-1:0] paddr_q;

    always_comb begin
        translation_req_o = 1'b0;
        valid_o           = 1'b0;
        ex_valid_o        = 1'b0;
        pop_st_o          = 1'b0;
        st_valid          = 1'b0;
        st_valid_nf       = 1'b0;
        state_d           = state_q;

        case (state_q)
            IDLE: begin
                if (valid_i) begin
                    translation_req_o = 1'b1;
                    pop_st_o          = 1'b1;
                    state_d           = VALID_STORE;
                    // no translation yet, keep the store at issue
                    if (!dtlb_hit_i) begin
                        pop_st_o = 1'b0;
                        state_d  = WAIT_TRANSLATION;
                    end
                    // queue has no room, stall as well
                    if (!st_ready_i) begin
                        pop_st_o = 1'b0;
                        state_d  = WAIT_STORE_READY;
                    end
                end
            end

            VALID_STORE: begin
                // writeback for the store accepted last cycle
                valid_o     = 1'b1;
                st_valid    = !flush_i;
                st_valid_nf = 1'b1;
                // back to back store, same checks as from idle
                if (valid_i) begin
                    translation_req_o = 1'b1;
                    pop_st_o          = 1'b1;
                    state_d           = VALID_STORE;
                    if (!dtlb_hit_i) begin
                        pop_st_o = 1'b0;
                        state_d  = WAIT_TRANSLATION;
                    end
                    if (!st_ready_i) begin
                        pop_st_o = 1'b0;
                        state_d  = WAIT_STORE_READY;
                    end
                end else begin
                    state_d = IDLE;
                end
            end

            WAIT_STORE_READY: begin
                // hold the request until room and a hit coincide
                translation_req_o = 1'b1;
                if (st_ready_i && dtlb_hit_i) begin
                    state_d = IDLE;
                end
            end

            WAIT_TRANSLATION: begin
                // the queue had room on entry, only the TLB is missing
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = IDLE;
                end
            end

            default: state_d = IDLE;
        endcase

        // --------------------
        // translation exception
        // --------------------
        // retire the store towards issue and writeback but never post it
        if (ex_valid_i && (state_q != IDLE)) begin
            pop_st_o   = 1'b1;
            valid_o    = 1'b1;
            ex_valid_o = 1'b1;
            st_valid   = 1'b0;
            state_d    = IDLE;
        end

        if (flush_i) begin
            state_d = IDLE;
        end
    end

    assign st.valid    = st_valid;
    assign st.valid_nf = st_valid_nf;
    assign st.paddr    = paddr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // translated address of the accepted store, used in the post cycle
    always_ff @(posedge clk_i) begin
        if (pop_st_o) begin
            paddr_q <= paddr_i;
        end
    end

endmodule

// ==== verilog/store_align.sv ====
/*
 * second cycle register stage of the store path
 * shifts the write data to the byte offset of the address and
 * derives the transfer size; the transaction id is kept for writeback
 */
module store_align (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  store_pkg::store_op_e              op_i,
    input  logic [store_pkg::ADDR_W-1:0]      vaddr_i,
    input  logic [store_pkg::XLEN-1:0]        data_i,
    input  logic [store_pkg::XLEN/8-1:0]      be_i,
    input  logic [store_pkg::TRANS_ID_W-1:0]  trans_id_i,
    output logic [store_pkg::TRANS_ID_W-1:0]  trans_id_o,
    store_req_if.ctrl                         st
);
    import store_pkg::*;

    logic [XLEN-1:0]       data_n, data_q;
    logic [XLEN/8-1:0]     be_q;
    logic [1:0]            size_n, size_q;
    logic [TRANS_ID_W-1:0] trans_id_q;

    // --------------------
    // realign
    // --------------------
    // one byte lane per unit of the low address bits
    assign data_n = data_i << {vaddr_i[2:0], 3'b000};

    always_comb begin
        case (op_i)
            ST_SB:   size_n = 2'd0;
            ST_SH:   size_n = 2'd1;
            ST_SW:   size_n = 2'd2;
            default: size_n = 2'd3;
        endcase
    end

    // sampled every cycle, valid whenever the FSM posts next cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            size_q     <= 2'd0;
            trans_id_q <= '0;
        end else begin
            size_q     <= size_n;
            trans_id_q <= trans_id_i;
        end
    end

    always_ff @(posedge clk_i) begin
        data_q <= data_n;
        be_q   <= be_i;
    end

    assign st.data    = data_q;
    assign st.be      = be_q;
    assign st.size    = size_q;
    assign trans_id_o = trans_id_q;

endmodule

// ==== verilog/queue_level_counter.sv ====
/*
 * occupancy counts of the speculative and committed store queues
 * push and commit move the speculative count, commit and retire the
 * committed one; flush drops the speculative count only
 */
module queue_level_counter (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    input  logic push_i,
    input  logic commit_i,
    input  logic retire_i,
    output logic spec_full_o,
    output logic commit_full_o,
    output logic empty_o
);
    import store_pkg::*;

    logic [LEVEL_W-1:0] spec_cnt_q;
    logic [LEVEL_W-1:0] commit_cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            spec_cnt_q   <= '0;
            commit_cnt_q <= '0;
        end else begin
            // a commit still lands in the committed queue during a flush
            if (flush_i) begin
                spec_cnt_q <= '0;
            end else if (push_i && !commit_i) begin
                spec_cnt_q <= spec_cnt_q + 1'b1;
            end else if (commit_i && !push_i) begin
                spec_cnt_q <= spec_cnt_q - 1'b1;
            end

            if (commit_i && !retire_i) begin
                commit_cnt_q <= commit_cnt_q + 1'b1;
            end else if (retire_i && !commit_i) begin
                commit_cnt_q <= commit_cnt_q - 1'b1;
            end
        end
    end

    // count the post in flight too, a store accepted now lands next cycle
    assign spec_full_o   = (spec_cnt_q + LEVEL_W'(push_i)) >= LEVEL_W'(SPEC_DEPTH);
    assign commit_full_o = commit_cnt_q == LEVEL_W'(COMMIT_DEPTH);
    assign empty_o       = (spec_cnt_q == '0) && (commit_cnt_q == '0);

endmodule

// ==== verilog/store_queue.sv ====
/*
 * speculative and committed store queues
 * posts land in the speculative ring, commit_i moves the oldest one to
 * the committed ring, whose head drains to the memory port on grant;
 * also answers whether a page offset hits any pending store
 */
module store_queue (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    input  logic                          commit_i,
    store_req_if.queue                    st,
    output logic                          ready_o,
    output logic                          commit_ready_o,
    output logic                          no_st_pending_o,
    output logic                          store_buffer_empty_o,
    input  logic [8:0]                    page_offset_i,
    output logic                          page_offset_matches_o,
    output logic                          mem_req_o,
    input  logic                          mem_gnt_i,
    output logic [store_pkg::ADDR_W-1:0]  mem_addr_o,
    output logic [store_pkg::XLEN-1:0]    mem_wdata_o,
    output logic [store_pkg::XLEN/8-1:0]  mem_be_o,
    output logic [1:0]                    mem_size_o
);
    import store_pkg::*;

    store_entry_t                    spec_mem_q [SPEC_DEPTH];
    logic [SPEC_DEPTH-1:0]           spec_valid_q;
    logic [$clog2(SPEC_DEPTH)-1:0]   spec_wptr_q, spec_rptr_q;
    store_entry_t                    commit_mem_q [COMMIT_DEPTH];
    logic [COMMIT_DEPTH-1:0]         commit_valid_q;
    logic [$clog2(COMMIT_DEPTH)-1:0] commit_wptr_q, commit_rptr_q;
    store_entry_t                    head;
    logic                            retire;
    logic                            spec_full;
    logic                            commit_full;

    // --------------------
    // entry storage
    // --------------------
    always_ff @(posedge clk_i) begin
        if (st.valid) begin
            spec_mem_q[spec_wptr_q] <= '{paddr: st.paddr, data: st.data,
                                         be: st.be, size: st.size};
        end
        // oldest speculative store becomes architectural
        if (commit_i) begin
            commit_mem_q[commit_wptr_q] <= spec_mem_q[spec_rptr_q];
        end
    end

    // valid bits and pointers
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            spec_valid_q   <= '0;
            spec_wptr_q    <= '0;
            spec_rptr_q    <= '0;
            commit_valid_q <= '0;
            commit_wptr_q  <= '0;
            commit_rptr_q  <= '0;
        end else begin
            if (st.valid) begin
                spec_valid_q[spec_wptr_q] <= 1'b1;
                spec_wptr_q               <= spec_wptr_q + 1'b1;
            end
            if (commit_i) begin
                spec_valid_q[spec_rptr_q]     <= 1'b0;
                spec_rptr_q                   <= spec_rptr_q + 1'b1;
                commit_valid_q[commit_wptr_q] <= 1'b1;
                commit_wptr_q                 <= commit_wptr_q + 1'b1;
            end
            if (retire) begin
                commit_valid_q[commit_rptr_q] <= 1'b0;
                commit_rptr_q                 <= commit_rptr_q + 1'b1;
            end
            // speculative stores die, committed ones keep draining
            if (flush_i) begin
                spec_valid_q <= '0;
                spec_wptr_q  <= '0;
                spec_rptr_q  <= '0;
            end
        end
    end

    // --------------------
    // memory port
    // --------------------
    assign head        = commit_mem_q[commit_rptr_q];
    assign mem_req_o   = commit_valid_q[commit_rptr_q];
    assign mem_addr_o  = head.paddr;
    assign mem_wdata_o = head.data;
    assign mem_be_o    = head.be;
    assign mem_size_o  = head.size;
    assign retire      = mem_req_o & mem_gnt_i;

    // address checker, loads stall on any overlap in the same doubleword
    always_comb begin
        page_offset_matches_o = st.valid_nf && (st.paddr[11:3] == page_offset_i);
        for (int i = 0; i < SPEC_DEPTH; i++) begin
            if (spec_valid_q[i] && (spec_mem_q[i].paddr[11:3] == page_offset_i)) begin
                page_offset_matches_o = 1'b1;
            end
        end
        for (int i = 0; i < COMMIT_DEPTH; i++) begin
            if (commit_valid_q[i] && (commit_mem_q[i].paddr[11:3] == page_offset_i)) begin
                page_offset_matches_o = 1'b1;
            end
        end
    end

    queue_level_counter u_queue_level_counter (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .push_i        (st.valid),
        .commit_i      (commit_i),
        .retire_i      (retire),
        .spec_full_o   (spec_full),
        .commit_full_o (commit_full),
        .empty_o       (store_buffer_empty_o)
    );

    assign ready_o         = ~spec_full;
    assign commit_ready_o  = ~commit_full;
    assign no_st_pending_o = ~|commit_valid_q;

endmodule

// ==== verilog/store_unit_top.sv ====
/*
 * store path of the load/store unit
 * plain ports towards issue, writeback, the TLB and the memory port;
 * the TLB answers in the same cycle as translation_req_o
 */
module store_unit_top (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              flush_i,
    // issue side
    input  logic                              valid_i,
    input  store_pkg::store_op_e              op_i,
    input  logic [store_pkg::ADDR_W-1:0]      vaddr_i,
    input  logic [store_pkg::XLEN-1:0]        data_i,
    input  logic [store_pkg::XLEN/8-1:0]      be_i,
    input  logic [store_pkg::TRANS_ID_W-1:0]  trans_id_i,
    output logic                              pop_st_o,
    input  logic                              commit_i,
    output logic                              commit_ready_o,
    // writeback
    output logic                              valid_o,
    output logic [store_pkg::TRANS_ID_W-1:0]  trans_id_o,
    output logic                              ex_valid_o,
    // TLB
    output logic                              translation_req_o,
    output logic [store_pkg::ADDR_W-1:0]      vaddr_o,
    input  logic [store_pkg::ADDR_W-1:0]      paddr_i,
    input  logic                              ex_valid_i,
    input  logic                              dtlb_hit_i,
    // address checker and status
    input  logic [8:0]                        page_offset_i,
    output logic                              page_offset_matches_o,
    output logic                              no_st_pending_o,
    output logic                              store_buffer_empty_o,
    // memory port
    output logic                              mem_req_o,
    input  logic                              mem_gnt_i,
    output logic [store_pkg::ADDR_W-1:0]      mem_addr_o,
    output logic [store_pkg::XLEN-1:0]        mem_wdata_o,
    output logic [store_pkg::XLEN/8-1:0]      mem_be_o,
    output logic [1:0]                        mem_size_o
);

    logic st_ready;

    store_req_if st_if ();

    // the TLB sees the issue address untouched
    assign vaddr_o = vaddr_i;

    store_ctrl u_store_ctrl (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .flush_i           (flush_i),
        .valid_i           (valid_i),
        .pop_st_o          (pop_st_o),
        .valid_o           (valid_o),
        .ex_valid_i        (ex_valid_i),
        .ex_valid_o        (ex_valid_o),
        .translation_req_o (translation_req_o),
        .dtlb_hit_i        (dtlb_hit_i),
        .paddr_i           (paddr_i),
        .st_ready_i        (st_ready),
        .st                (st_if.ctrl)
    );

    store_align u_store_align (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .op_i       (op_i),
        .vaddr_i    (vaddr_i),
        .data_i     (data_i),
        .be_i       (be_i),
        .trans_id_i (trans_id_i),
        .trans_id_o (trans_id_o),
        .st         (st_if.ctrl)
    );

    store_queue u_store_queue (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .commit_i              (commit_i),
        .st                    (st_if.queue),
        .ready_o               (st_ready),
        .commit_ready_o        (commit_ready_o),
        .no_st_pending_o       (no_st_pending_o),
        .store_buffer_empty_o  (store_buffer_empty_o),
        .page_offset_i         (page_offset_i),
        .page_offset_matches_o (page_offset_matches_o),
        .mem_req_o             (mem_req_o),
        .mem_gnt_i             (mem_gnt_i),
        .mem_addr_o            (mem_addr_o),
        .mem_wdata_o           (mem_wdata_o),
        .mem_be_o              (mem_be_o),
        .mem_size_o            (mem_size_o)
    );

endmodule

// ==== verification/tb_store_unit.sv ====
/*
 * testbench for the store path of the load/store unit
 * models the TLB (xor translation, random misses) and a memory port with
 * random grants; expected stores follow speculative, committed and flushed
 * state and are compared at the memory port in program order
 */
module tb_store_unit;
    timeunit 1ns;
    timeprecision 1ps;
    import store_pkg::*;

    localparam logic [31:0] TLB_KEY = 32'h5a5a_0000;
    // 24 plain, 5 around the flush, 3 with one exception, 9 under back-pressure
    localparam int N_STORES = 41;
    localparam int WATCHDOG_CYCLES = N_STORES * 40 + 300;

    logic                  clk_i;
    logic                  rst_ni;
    logic                  flush_i;
    logic                  valid_i;
    store_op_e             op_i;
    logic [ADDR_W-1:0]     vaddr_i;
    logic [XLEN-1:0]       data_i;
    logic [XLEN/8-1:0]     be_i;
    logic [TRANS_ID_W-1:0] trans_id_i;
    logic                  pop_st_o;
    logic                  commit_i;
    logic                  commit_ready_o;
    logic                  valid_o;
    logic [TRANS_ID_W-1:0] trans_id_o;
    logic                  ex_valid_o;
    logic                  translation_req_o;
    logic [ADDR_W-1:0]     vaddr_o;
    logic [ADDR_W-1:0]     paddr_i;
    logic                  ex_valid_i;
    logic                  dtlb_hit_i;
    logic [8:0]            page_offset_i;
    logic                  page_offset_matches_o;
    logic                  no_st_pending_o;
    logic                  store_buffer_empty_o;
    logic                  mem_req_o;
    logic                  mem_gnt_i;
    logic [ADDR_W-1:0]     mem_addr_o;
    logic [XLEN-1:0]       mem_wdata_o;
    logic [XLEN/8-1:0]     mem_be_o;
    logic [1:0]            mem_size_o;

    int seed = 14966;
    int errors = 0;
    int issued = 0;
    int commits = 0;
    int writes = 0;
    int exc_count = 0;

    // expected stores, posted but not committed, and committed but not written
    store_entry_t spec_exp[$];
    store_entry_t mem_exp[$];
    store_entry_t wb_entry;
    store_entry_t exp_entry;
    logic                  wb_pending = 1'b0;
    logic [TRANS_ID_W-1:0] wb_id;
    logic [TRANS_ID_W-1:0] next_id = '0;
    // outputs as seen mid cycle, read again on the next rising edge
    logic                  commit_ready_s = 1'b0;
    logic                  empty_s = 1'b0;
    logic                  gnt_enable = 1'b0;
    logic [31:0]           gnt_draw = '0;

    store_unit_top u_store_unit_top (.*);

    // translation keeps the page offset, only upper bits change
    assign paddr_i = vaddr_o ^ TLB_KEY;

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // --------------------
    // reference model
    // --------------------
    function automatic store_entry_t ref_store(input store_op_e op, input logic [31:0] vaddr,
                                               input logic [63:0] data, input logic [7:0] be);
        store_entry_t e;
        e.paddr = vaddr ^ TLB_KEY;
        e.data  = data;
        // one byte lane per unit of the doubleword offset
        for (int k = 0; k < int'(vaddr[2:0]); k++) begin
            e.data = {e.data[55:0], 8'h00};
        end
        e.be = be;
        case (op)
            ST_SB:   e.size = 2'd0;
            ST_SH:   e.size = 2'd1;
            ST_SW:   e.size = 2'd2;
            default: e.size = 2'd3;
        endcase
        return e;
    endfunction

    // natural alignment for the access width
    function automatic logic [2:0] align_offset(input store_op_e op, input logic [2:0] raw);
        case (op)
            ST_SB:   return raw;
            ST_SH:   return {raw[2:1], 1'b0};
            ST_SW:   return {raw[2], 2'b00};
            default: return 3'b000;
        endcase
    endfunction

    function automatic logic [7:0] lanes_for(input store_op_e op, input logic [2:0] off);
        case (op)
            ST_SB:   return 8'h01 << off;
            ST_SH:   return 8'h03 << off;
            ST_SW:   return 8'h0f << off;
            default: return 8'hff;
        endcase
    endfunction

    function automatic logic offset_in_use(input logic [8:0] off);
        foreach (spec_exp[i]) begin
            if (spec_exp[i].paddr[11:3] == off) return 1'b1;
        end
        foreach (mem_exp[i]) begin
            if (mem_exp[i].paddr[11:3] == off) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        errors++;
    endtask

    // --------------------
    // stimulus tasks
    // --------------------
    // back to back stores; exc_idx picks the one whose translation faults
    task automatic issue_batch(input int n, input int exc_idx);
        logic [31:0] rnd;
        logic [31:0] addr_rnd;
        logic [31:0] data_hi;
        logic [31:0] data_lo;
        store_op_e   op;
        logic [2:0]  off;
        logic        popped;
        logic        tr_seen;
        @(posedge clk_i);
        for (int i = 0; i < n; i++) begin
            rnd      = $random(seed);
            addr_rnd = $random(seed);
            data_hi  = $random(seed);
            data_lo  = $random(seed);
            op       = store_op_e'(rnd[1:0]);
            off      = align_offset(op, addr_rnd[2:0]);
            valid_i    <= 1'b1;
            op_i       <= op;
            vaddr_i    <= {addr_rnd[31:3], off};
            data_i     <= {data_hi, data_lo};
            be_i       <= lanes_for(op, off);
            trans_id_i <= next_id;
            next_id = next_id + 1'b1;
            issued++;
            tr_seen = 1'b0;
            popped  = 1'b0;
            while (!popped) begin
                rnd = $random(seed);
                // a faulting store never hits, its fault follows the request
                dtlb_hit_i <= (i != exc_idx) && (rnd[1:0] != 2'b00);
                ex_valid_i <= (i == exc_idx) && tr_seen;
                @(negedge clk_i);
                tr_seen = translation_req_o;
                popped  = pop_st_o;
                @(posedge clk_i);
            end
        end
        valid_i    <= 1'b0;
        dtlb_hit_i <= 1'b0;
        ex_valid_i <= 1'b0;
    endtask

    // one commit at a time, each waits for a posted store and room
    task automatic commit_n(input int n);
        for (int i = 0; i < n; i++) begin
            do begin
                @(posedge clk_i);
            end while (spec_exp.size() == 0 || !commit_ready_s);
            commit_i <= 1'b1;
            @(posedge clk_i);
            commit_i <= 1'b0;
            mem_exp.push_back(spec_exp.pop_front());
            commits++;
        end
    endtask

    task automatic apply_flush();
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        spec_exp.delete();
    endtask

    task automatic set_grants(input logic en);
        @(negedge clk_i);
        gnt_enable = en;
    endtask

    task automatic wait_drain();
        do begin
            @(posedge clk_i);
        end while (mem_exp.size() != 0 || !empty_s);
    endtask

    // loads would stall on a pending doubleword, and only on that
    task automatic check_offsets();
        logic [8:0] hit_off;
        logic [8:0] free_off;
        // the last post of the batch reaches the expected queue first
        @(posedge clk_i);
        hit_off  = spec_exp[1].paddr[11:3];
        free_off = 9'd0;
        while (offset_in_use(free_off)) begin
            free_off++;
        end
        page_offset_i <= hit_off;
        @(negedge clk_i);
        if (!page_offset_matches_o) begin
            report_mismatch($sformatf("no match for pending offset %0h", hit_off));
        end
        @(posedge clk_i);
        page_offset_i <= free_off;
        @(negedge clk_i);
        if (page_offset_matches_o) begin
            report_mismatch($sformatf("match for unused offset %0h", free_off));
        end
    endtask

    // --------------------
    // memory model
    // --------------------
    always @(negedge clk_i) begin
        gnt_draw = $random(seed);
    end

    always @(posedge clk_i) begin
        mem_gnt_i <= gnt_enable && gnt_draw[0];
    end

    // compare every granted write with the oldest committed store
    always @(negedge clk_i) begin
        if (rst_ni && mem_req_o && mem_gnt_i) begin
            writes++;
            if (mem_exp.size() == 0) begin
                $display("[FAIL] %0t: memory write at %h with no committed store outstanding",
                         $time, mem_addr_o);
                errors++;
            end else begin
                exp_entry = mem_exp.pop_front();
                if (mem_addr_o !== exp_entry.paddr || mem_wdata_o !== exp_entry.data ||
                    mem_be_o !== exp_entry.be || mem_size_o !== exp_entry.size) begin
                    report_mismatch($sformatf("write %h %h %h %0d, expected %h %h %h %0d",
                        mem_addr_o, mem_wdata_o, mem_be_o, mem_size_o, exp_entry.paddr,
                        exp_entry.data, exp_entry.be, exp_entry.size));
                end
            end
        end
    end

    // --------------------
    // pop and writeback checker
    // --------------------
    always @(negedge clk_i) begin
        commit_ready_s = commit_ready_o;
        empty_s        = store_buffer_empty_o;
        if (rst_ni) begin
            if (wb_pending) begin
                if (!valid_o || ex_valid_o || trans_id_o !== wb_id) begin
                    report_mismatch($sformatf("writeback valid %0b ex %0b id %0d, expected id %0d",
                                              valid_o, ex_valid_o, trans_id_o, wb_id));
                end
                // the post of this cycle is dropped by a flush
                if (!flush_i) begin
                    spec_exp.push_back(wb_entry);
                end
            end else if (valid_o && !ex_valid_o) begin
                report_mismatch("writeback without a pop one cycle before");
            end
            wb_pending = 1'b0;
            if (pop_st_o) begin
                if (ex_valid_o) begin
                    exc_count++;
                    if (!valid_o || trans_id_o !== trans_id_i) begin
                        report_mismatch($sformatf("exception writeback valid %0b id %0d",
                                                  valid_o, trans_id_o));
                    end
                end else begin
                    if (!dtlb_hit_i) begin
                        report_mismatch("pop_st_o high while dtlb_hit_i low");
                    end
                    wb_pending = 1'b1;
                    wb_id      = trans_id_i;
                    wb_entry   = ref_store(op_i, vaddr_i, data_i, be_i);
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, stores did not complete", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // --------------------
    // test sequence
    // --------------------
    initial begin
        rst_ni        = 1'b0;
        flush_i       = 1'b0;
        valid_i       = 1'b0;
        op_i          = ST_SB;
        vaddr_i       = '0;
        data_i        = '0;
        be_i          = '0;
        trans_id_i    = '0;
        commit_i      = 1'b0;
        ex_valid_i    = 1'b0;
        dtlb_hit_i    = 1'b0;
        page_offset_i = '0;
        mem_gnt_i     = 1'b0;
        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        if (pop_st_o || valid_o || translation_req_o || mem_req_o ||
            !no_st_pending_o || !store_buffer_empty_o) begin
            report_mismatch("outputs after reset not idle");
        end

        // in order drain with random misses and grants
        set_grants(1'b1);
        for (int r = 0; r < 6; r++) begin
            issue_batch(4, -1);
            commit_n(4);
        end
        wait_drain();

        // two committed survive, three speculative are dropped
        issue_batch(2, -1);
        commit_n(2);
        issue_batch(3, -1);
        apply_flush();
        wait_drain();

        // middle store faults in translation
        issue_batch(3, 1);
        commit_n(2);
        wait_drain();

        // back-pressure, both queues full before grants resume
        set_grants(1'b0);
        issue_batch(4, -1);
        commit_n(4);
        issue_batch(4, -1);
        check_offsets();
        fork
            issue_batch(1, -1);
            begin
                repeat (20) begin
                    @(negedge clk_i);
                    if (pop_st_o) begin
                        report_mismatch("pop_st_o high with both queues full");
                    end
                    if (commit_ready_o) begin
                        report_mismatch("commit_ready_o high with committed queue full");
                    end
                end
                set_grants(1'b1);
                commit_n(4);
            end
        join
        commit_n(1);
        wait_drain();
        @(negedge clk_i);
        if (!no_st_pending_o || !store_buffer_empty_o) begin
            report_mismatch("store buffer not empty after drain");
        end

        if (writes != commits || spec_exp.size() != 0) begin
            report_mismatch($sformatf("%0d writes for %0d commits", writes, commits));
        end
        if (exc_count != 1) begin
            report_mismatch($sformatf("%0d exception writebacks, expected 1", exc_count));
        end
        $display("issued %0d, committed %0d, written %0d, exceptions %0d, errors %0d",
                 issued, commits, writes, exc_count, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
verilog/store_pkg.sv
verilog/store_req_if.sv
verilog/store_ctrl.sv
verilog/store_align.sv
verilog/queue_level_counter.sv
verilog/store_queue.sv
verilog/store_unit_top.sv
verification/tb_store_unit.sv

// ==== Makefile ====
# Verilator build and run of the store unit testbench
# override any variable on the command line, e.g. make sim TOP=tb_store_unit

VERILATOR ?= verilator
TOP       ?= tb_store_unit
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
